/* vlog.f */
+incdir+common
common/z8Pkg.sv
core/z8Alu.sv
core/z8CondEval.sv
core/z8Sequencer.sv
src/z8Top.sv
tb/z8_checker.sv
tb/z8Tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := z8Tb
FILELIST  := vlog.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "FAIL: run ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/z8Tb.sv */
`timescale 1ns/10ps
`include "z8_defines.svh"

module z8Tb;
    import z8Pkg::*;

    // program bytes sit in the low bytes of code, first byte highest
    typedef struct packed {
        logic [79:0] code;
        logic [3:0]  len;
        logic [7:0]  expected;
    } testRowT;

    logic               clk = 1'b0;
    logic               rst;
    fetchReqT           fetch;
    fetchRspT           fetchRsp;
    logic [`DATA_W-1:0] port2;

    testRowT            tab[$];
    string              names[$];
    testRowT            curRow;
    logic [`ADDR_W-1:0] endAddr;
    logic               built = 1'b0;
    integer             seed = 32'h485fa4f3;
    int                 passCount = 0;
    int                 failCount = 0;

    z8Top u_z8Top (
        .clk      (clk),
        .rst      (rst),
        .fetch    (fetch),
        .fetchRsp (fetchRsp),
        .port2    (port2)
    );

    always #5 clk = ~clk;

    task automatic addRow(input string name, input logic [79:0] code, input int len,
                          input logic [7:0] expected);
        testRowT row;
        row.code = code;
        row.len = 4'(len);
        row.expected = expected;
        tab.push_back(row);
        names.push_back(name);
    endtask

    task automatic buildTable();
        logic [7:0] x;
        logic [7:0] y;
        x = 8'($random(seed));
        y = 8'($random(seed));
        addRow("nop, ld r2", 80'hFF2C5A, 3, 8'h5A);
        addRow("add", 80'({8'h2C, x, 8'h3C, y, 8'h02, 8'h23}), 6, x + y);
        addRow("scf, adc", 80'({8'hDF, 8'h2C, x, 8'h3C, y, 8'h12, 8'h23}), 7, x + y + 8'd1);
        addRow("sub", 80'({8'h2C, x, 8'h3C, y, 8'h22, 8'h23}), 6, x - y);
        addRow("scf, sbc", 80'({8'hDF, 8'h2C, x, 8'h3C, y, 8'h32, 8'h23}), 7, x - y - 8'd1);
        addRow("or", 80'h2C5A3C0F4223, 6, 8'h5F);
        addRow("and", 80'h2C5A3C0F5223, 6, 8'h0A);
        addRow("xor", 80'h2C5A3C0FB223, 6, 8'h55);
        // flag-only ops, then jr over ld r2,#11
        addRow("cp, jr z", 80'h2C5A3C5AA2236B022C11, 10, 8'h5A);
        addRow("tm, jr z", 80'h2CF03C0F72236B022C11, 10, 8'hF0);
        addRow("tcm, jr nz", 80'h2CF03C0F6223EB022C11, 10, 8'hF0);
        addRow("jr taken", 80'h2C228B022C33, 6, 8'h22);
        addRow("jr not taken", 80'h2C220B022C33, 6, 8'h33);
        addRow("jp taken", 80'h2C448D00132C55, 7, 8'h44);
        addRow("jp not taken", 80'h2C440D00132C55, 7, 8'h55);
        // six passes of inc r2 and djnz r3
        addRow("djnz loop", 80'h3C062C002E3AFD, 7, 8'h06);
        addRow("scf, ccf, jr c", 80'h2C77DFEF7B022C66, 8, 8'h66);
        addRow("rcf, ccf, jr c", 80'h2C77CFEF7B022C66, 8, 8'h77);
    endtask

    function automatic logic [`DATA_W-1:0] progByte(input testRowT row,
                                                    input logic [`ADDR_W-1:0] addr);
        int          idx;
        logic [79:0] shifted;
        idx = int'(addr - `RESET_PC);
        shifted = row.code >> (8 * (int'(row.len) - 1 - idx));
        return shifted[7:0];
    endfunction

    task automatic startTest(input int idx);
        @(posedge clk);
        #1;
        rst = 1'b1;
        curRow = tab[idx];
        endAddr = `RESET_PC + 16'(tab[idx].len);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic checkResult(input int idx, input logic [7:0] got);
        if (got !== tab[idx].expected) begin
            $display("Mismatch at %0t ns: %s gave port2=%02h, expected %02h",
                     $time, names[idx], got, tab[idx].expected);
            failCount++;
        end else begin
            $display("test %0d %s ok, port2=%02h", idx, names[idx], got);
            passCount++;
        end
    endtask

    // program memory on the far side of the fetch handshake
    initial begin : responder
        int                 delay;
        logic               reqNow;
        logic               ackNow;
        logic               rstNow;
        logic               inRange;
        logic [`DATA_W-1:0] byteNow;
        fetchRsp = '0;
        delay = -1;
        forever begin
            @(posedge clk);
            reqNow = fetch.req;
            ackNow = fetchRsp.ack;
            rstNow = rst;
            inRange = (fetch.addr >= `RESET_PC) && (fetch.addr < endAddr);
            byteNow = inRange ? progByte(curRow, fetch.addr) : 8'hFF;
            #1;
            if (rstNow) begin
                fetchRsp = '0;
                delay = -1;
            end else if (ackNow) begin
                if (!reqNow) begin
                    fetchRsp.ack = 1'b0;
                end
            end else if (reqNow && inRange) begin
                if (delay < 0) begin
                    delay = $random(seed) & 3;
                end
                if (delay == 0) begin
                    fetchRsp.data = byteNow;
                    fetchRsp.ack = 1'b1;
                    delay = -1;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : main
        logic [`DATA_W-1:0] got;
        rst = 1'b1;
        curRow = '0;
        endAddr = `RESET_PC;
        buildTable();
        built = 1'b1;
        for (int t = 0; t < tab.size(); t++) begin
            startTest(t);
            // done once the core asks for a byte past the program
            do begin
                @(posedge clk);
            end while (!(fetch.req && fetch.addr >= endAddr));
            got = port2;
            checkResult(t, got);
        end
        $display("%0d tests ok, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (built);
        // 10 bytes of 40 cycles for every test
        repeat (tab.size() * 10 * 40) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", tab.size() * 400);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tb/z8_checker.sv */
`timescale 1ns/10ps
`include "z8_defines.svh"

module z8Checker (
    input logic               clk,
    input logic               rst,
    input z8Pkg::fetchReqT    fetch,
    input z8Pkg::fetchRspT    fetchRsp,
    input logic [`DATA_W-1:0] port2
);

    // address held while the request waits for ack
    addrStable: assert property (@(posedge clk) disable iff (rst)
        (fetch.req && !fetchRsp.ack) |=> $stable(fetch.addr))
        else $error("fetch addr changed while req was waiting for ack");

    captureDropsReq: assert property (@(posedge clk) disable iff (rst)
        (fetch.req && fetchRsp.ack) |=> !fetch.req)
        else $error("req still high after a captured byte");

    // no new request until ack is low again
    reqLowDuringAck: assert property (@(posedge clk) disable iff (rst)
        (!fetch.req && fetchRsp.ack) |=> !fetch.req)
        else $error("req raised while ack was still high");

    portClearedByReset: assert property (@(posedge clk)
        rst |=> (port2 == '0))
        else $error("port2 not zero after reset");

endmodule

bind z8Top z8Checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .fetch    (fetch),
    .fetchRsp (fetchRsp),
    .port2    (port2)
);

/* src/z8Top.sv */
`timescale 1ns/10ps
`include "z8_defines.svh"

module z8Top (
    input  logic               clk,
    input  logic               rst,
    output z8Pkg::fetchReqT    fetch,
    input  z8Pkg::fetchRspT    fetchRsp,
    output logic [`DATA_W-1:0] port2
);
    import z8Pkg::*;

    aluOpT              aluOp;
    logic [`DATA_W-1:0] aluA;
    logic [`DATA_W-1:0] aluB;
    flagsT              flagsQ;
    flagsT              flagsOut;
    logic [3:0]         cond;
    logic [`DATA_W-1:0] aluOut;
    logic               writesResult;
    logic               takeBranch;

    z8Sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .fetch        (fetch),
        .fetchRsp     (fetchRsp),
        .aluOp        (aluOp),
        .aluA         (aluA),
        .aluB         (aluB),
        .flagsQ       (flagsQ),
        .cond         (cond),
        .aluOut       (aluOut),
        .flagsOut     (flagsOut),
        .writesResult (writesResult),
        .takeBranch   (takeBranch),
        .port2        (port2)
    );

    // ALU and condition check see the same flags
    z8Alu u_alu (
        .op           (aluOp),
        .a            (aluA),
        .b            (aluB),
        .flagsIn      (flagsQ),
        .result       (aluOut),
        .flagsOut     (flagsOut),
        .writesResult (writesResult)
    );

    z8CondEval u_cond (
        .cond       (cond),
        .flags      (flagsQ),
        .takeBranch (takeBranch)
    );

endmodule

/* core/z8Sequencer.sv */
`timescale 1ns/10ps
`include "z8_defines.svh"

module z8Sequencer (
    input  logic               clk,
    input  logic               rst,
    output z8Pkg::fetchReqT    fetch,
    input  z8Pkg::fetchRspT    fetchRsp,
    output z8Pkg::aluOpT       aluOp,
    output logic [`DATA_W-1:0] aluA,
    output logic [`DATA_W-1:0] aluB,
    output z8Pkg::flagsT       flagsQ,
    output logic [3:0]         cond,
    input  logic [`DATA_W-1:0] aluOut,
    input  z8Pkg::flagsT       flagsOut,
    input  logic               writesResult,
    input  logic               takeBranch,
    output logic [`DATA_W-1:0] port2
);
    import z8Pkg::*;

    localparam int RegIdxW = $clog2(`NUM_REGS);

    typedef enum logic [1:0] {
        stFetch,
        stAckLow,
        stExec
    } stateT;

    stateT              state;
    logic [`ADDR_W-1:0] pc;
    logic [1:0]         byteIdx;
    instrByteT          instr;
    instrByteT          second;
    logic [`DATA_W-1:0] third;
    logic [`DATA_W-1:0] regs [`NUM_REGS];
    logic [`DATA_W-1:0] portQ;

    // size from the column nibble
    function automatic logic [1:0] instrSize(input logic [3:0] col);
        logic [1:0] size;
        size = 2'd2;
        if (col[3:1] == 3'b111) begin
            size = 2'd1;
        end else if (col == 4'hD) begin
            size = 2'd3;
        end
        return size;
    endfunction

    logic               capture;
    logic               ackLow;
    logic [1:0]         curSize;
    logic               lastByte;
    logic               isExec;
    logic               isLdImm;
    logic               isAlu2;
    logic               isInc;
    logic               isJr;
    logic               isJp;
    logic               isDjnz;
    logic               isFlagOp;
    logic [RegIdxW-1:0] dstIdx;
    logic               writeReg;
    logic               writeFlags;
    logic [`ADDR_W-1:0] relTarget;
    logic [`ADDR_W-1:0] absTarget;

    assign capture = (state == stFetch) && fetchRsp.ack;
    assign ackLow = !fetchRsp.ack;
    assign curSize = (byteIdx == 2'd0) ? instrSize(fetchRsp.data[3:0]) : instrSize(instr.lo);
    assign lastByte = (byteIdx + 2'd1) == curSize;

    assign fetch.req = (state == stFetch);
    assign fetch.addr = pc;

    // decode of the assembled instruction
    assign isExec = (state == stExec);
    assign isLdImm = (instr.lo == 4'hC);
    assign isAlu2 = (instr.lo == 4'h2) && (!instr.hi[3] || instr.hi[3:1] == 3'b101);
    assign isInc = (instr.lo == 4'hE);
    assign isJr = (instr.lo == 4'hB);
    assign isJp = (instr.lo == 4'hD);
    assign isDjnz = (instr.lo == 4'hA);
    // rcf, scf, ccf
    assign isFlagOp = (instr.lo == 4'hF) && (instr.hi[3:2] == 2'b11) && (instr.hi != 4'hF);

    assign dstIdx = isAlu2 ? second.hi : instr.hi;
    assign aluA = regs[dstIdx];
    assign aluB = isLdImm ? second : regs[second.lo];
    assign cond = instr.hi;

    always_comb begin
        aluOp = opLd;
        if (isAlu2) begin
            aluOp = aluOpT'({1'b1, instr.hi});
        end else if (isInc) begin
            aluOp = opInc;
        end else if (isDjnz) begin
            aluOp = opDec;
        end
    end

    assign writeReg = isExec && writesResult && (isAlu2 || isLdImm || isInc || isDjnz);
    assign writeFlags = isExec && (isAlu2 || isInc);

    // pc already points past the last byte here
    assign relTarget = pc + {{(`ADDR_W-`DATA_W){second.hi[3]}}, second};
    assign absTarget = {second, third};

    always_ff @(posedge clk) begin
        if (capture) begin
            case (byteIdx)
                2'd0: instr <= instrByteT'(fetchRsp.data);
                2'd1: second <= instrByteT'(fetchRsp.data);
                default: third <= fetchRsp.data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stAckLow;
            pc <= `RESET_PC;
            byteIdx <= 2'd0;
            flagsQ.raw <= '0;
            portQ <= '0;
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                stFetch: begin
                    if (capture) begin
                        pc <= pc + 1'b1;
                        if (lastByte) begin
                            byteIdx <= 2'd0;
                            state <= stExec;
                        end else begin
                            byteIdx <= byteIdx + 2'd1;
                            state <= stAckLow;
                        end
                    end
                end
                stAckLow: begin
                    if (ackLow) begin
                        state <= stFetch;
                    end
                end
                default: begin
                    if (writeReg) begin
                        regs[dstIdx] <= aluOut;
                        if (dstIdx == RegIdxW'(`PORT_REG)) begin
                            portQ <= aluOut;
                        end
                    end
                    if (writeFlags) begin
                        flagsQ.raw <= flagsOut.raw;
                    end else if (isFlagOp) begin
                        case (instr.hi)
                            4'hC: flagsQ.bits.c <= 1'b0;
                            4'hD: flagsQ.bits.c <= 1'b1;
                            default: flagsQ.bits.c <= ~flagsQ.bits.c;
                        endcase
                    end
                    // djnz loops while the decremented count is nonzero
                    if ((isJr && takeBranch) || (isDjnz && aluOut != '0)) begin
                        pc <= relTarget;
                    end else if (isJp && takeBranch) begin
                        pc <= absTarget;
                    end
                    state <= ackLow ? stFetch : stAckLow;
                end
            endcase
        end
    end

    assign port2 = portQ;

endmodule

/* core/z8CondEval.sv */
`timescale 1ns/10ps

module z8CondEval (
    input  logic [3:0]   cond,
    input  z8Pkg::flagsT flags,
    output logic         takeBranch
);
    import z8Pkg::*;

    logic rawCond;

    always_comb begin
        case (cond[2:0])
            3'd0: rawCond = 1'b0;
            3'd1: rawCond = flags.bits.s ^ flags.bits.v;
            3'd2: rawCond = (flags.bits.s ^ flags.bits.v) | flags.bits.z;
            3'd3: rawCond = flags.bits.c | flags.bits.z;
            3'd4: rawCond = flags.bits.v;
            3'd5: rawCond = flags.bits.s;
            3'd6: rawCond = flags.bits.z;
            default: rawCond = flags.bits.c;
        endcase
    end

    // upper half of the table is the negated condition, 8 is always
    assign takeBranch = rawCond ^ cond[3];

endmodule

/* core/z8Alu.sv */
`timescale 1ns/10ps
`include "z8_defines.svh"

module z8Alu (
    input  z8Pkg::aluOpT       op,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  z8Pkg::flagsT       flagsIn,
    output logic [`DATA_W-1:0] result,
    output z8Pkg::flagsT       flagsOut,
    output logic               writesResult
);
    import z8Pkg::*;

    localparam int Msb = `DATA_W - 1;

    logic [`DATA_W-1:0] addB;
    logic               carryIn;
    logic               isSub;
    logic [`DATA_W:0]   sum;
    logic [4:0]         halfSum;
    logic               overflow;
    logic [`DATA_W-1:0] logicR;

    // one adder serves add, sub, inc and dec
    always_comb begin
        addB = b;
        carryIn = 1'b0;
        isSub = 1'b0;
        case (op)
            opAdc: carryIn = flagsIn.bits.c;
            opSub, opCp: begin
                addB = ~b;
                carryIn = 1'b1;
                isSub = 1'b1;
            end
            opSbc: begin
                addB = ~b;
                carryIn = ~flagsIn.bits.c;
                isSub = 1'b1;
            end
            opInc: begin
                addB = '0;
                carryIn = 1'b1;
            end
            // a + 0xFE + 1 is a - 1
            opDec: begin
                addB = {{(`DATA_W-1){1'b1}}, 1'b0};
                carryIn = 1'b1;
            end
            default: ;
        endcase
    end

    assign sum = {1'b0, a} + {1'b0, addB} + {{`DATA_W{1'b0}}, carryIn};
    assign halfSum = {1'b0, a[3:0]} + {1'b0, addB[3:0]} + {4'b0, carryIn};
    assign overflow = (a[Msb] == addB[Msb]) && (sum[Msb] != a[Msb]);

    always_comb begin
        case (op)
            opOr:    logicR = a | b;
            opAnd:   logicR = a & b;
            opTm:    logicR = a & b;
            opTcm:   logicR = ~a & b;
            default: logicR = a ^ b;
        endcase
    end

    always_comb begin
        flagsOut = flagsIn;
        result = sum[Msb:0];
        writesResult = 1'b1;
        case (op)
            opAdd, opAdc, opSub, opSbc, opCp: begin
                // borrow is the inverted carry out
                flagsOut.bits.c = sum[`DATA_W] ^ isSub;
                flagsOut.bits.z = (sum[Msb:0] == '0);
                flagsOut.bits.s = sum[Msb];
                flagsOut.bits.v = overflow;
                if (op == opCp) begin
                    writesResult = 1'b0;
                end else begin
                    flagsOut.bits.d = isSub;
                    flagsOut.bits.h = halfSum[4] ^ isSub;
                end
            end
            opOr, opAnd, opXor, opTm, opTcm: begin
                result = logicR;
                flagsOut.bits.z = (logicR == '0);
                flagsOut.bits.s = logicR[Msb];
                flagsOut.bits.v = 1'b0;
                writesResult = !(op == opTm || op == opTcm);
            end
            opInc, opDec: begin
                flagsOut.bits.z = (sum[Msb:0] == '0);
                flagsOut.bits.s = sum[Msb];
                flagsOut.bits.v = overflow;
            end
            default: result = b;
        endcase
    end

endmodule

/* common/z8Pkg.sv */
`include "z8_defines.svh"

package z8Pkg;

    // reference bit order, c in the top bit
    typedef struct packed {
        logic c;
        logic z;
        logic s;
        logic v;
        logic d;
        logic h;
        logic u2;
        logic u1;
    } flagBitsT;

    typedef union packed {
        logic [`DATA_W-1:0] raw;
        flagBitsT           bits;
    } flagsT;

    // upper bit set for the two-operand group, low nibble from the opcode row
    typedef enum logic [4:0] {
        opDec = 5'h00,
        opInc = 5'h02,
        opLd  = 5'h0C,
        opAdd = 5'h10,
        opAdc = 5'h11,
        opSub = 5'h12,
        opSbc = 5'h13,
        opOr  = 5'h14,
        opAnd = 5'h15,
        opTcm = 5'h16,
        opTm  = 5'h17,
        opCp  = 5'h1A,
        opXor = 5'h1B
    } aluOpT;

    // opcode byte, hi is the row and lo the column
    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } instrByteT;

    typedef struct packed {
        logic              req;
        logic [`ADDR_W-1:0] addr;
    } fetchReqT;

    typedef struct packed {
        logic              ack;
        logic [`DATA_W-1:0] data;
    } fetchRspT;

endpackage

/* common/z8_defines.svh */
`ifndef Z8_DEFINES_SVH
`define Z8_DEFINES_SVH

// width of data bytes and registers
`define DATA_W 8

// program address width
`define ADDR_W 16

// working registers r0..rF
`define NUM_REGS 16

// first instruction fetched after reset
`define RESET_PC 16'h000C

// working register mirrored to port 2
`define PORT_REG 2

`endif
